//--- bench/video_scanout_tb.sv
// Testbench for the video scanout.
// Clock, reset, video memory model and value checker.
// Directed tests for registers, palette and direct modes, stalls, frames and blanking.

`timescale 1ns/1ps
`default_nettype none

module video_scanout_tb;

	localparam int MAX_PITCH = 640;

	// Rough cycle budget per kind of step.
	localparam int CPU_ACCESS_CYCLES = 6;
	localparam int FETCH_CYCLES = 64;
	localparam int SCAN_CYCLES = 48;
	localparam int TEST_CYCLES = 280 * CPU_ACCESS_CYCLES + 10 * FETCH_CYCLES +
		10 * SCAN_CYCLES + 6 * 16;
	localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

	logic clock;
	logic rst_n;
	logic cpu_request;
	video_cfg_pkg::cpu_req_t cpu_req;
	logic cpu_ready;
	logic [31:0] cpu_rdata;
	video_pix_pkg::raster_t raster;
	video_pix_pkg::rgb_t rgb;
	logic vram_request;
	logic [31:0] vram_address;
	logic vram_ready;
	logic [31:0] vram_rdata;

	int errors;
	int checks;
	int cycles;
	int seed;
	int line_num;
	int cur_pitch;
	logic [31:0] cur_offset;
	logic cur_pal;
	logic [31:0] buf_base;
	logic stall_en;
	logic [23:0] pal_model [256];
	logic [31:0] fetch_log [$];

	video_scanout #(
		.MAX_PITCH(MAX_PITCH)
	) i_dut (
		.i_clock(clock),
		.i_rst_n(rst_n),
		.i_cpu_request(cpu_request),
		.i_cpu_req(cpu_req),
		.o_cpu_ready(cpu_ready),
		.o_cpu_rdata(cpu_rdata),
		.i_raster(raster),
		.o_video_rgb(rgb),
		.o_vram_request(vram_request),
		.o_vram_address(vram_address),
		.i_vram_ready(vram_ready),
		.i_vram_rdata(vram_rdata)
	);

	always #4 clock = ~clock;

	// ========================================================================
	// Models and helpers.
	// ========================================================================

	// Memory contents, mixed from every address bit.
	function automatic logic [31:0] model_word(input logic [31:0] a);
		return (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]};
	endfunction

	function automatic logic [23:0] palette_colour(input int i);
		logic [7:0] b;
		b = i[7:0];
		return {b, b ^ 8'h3C, ~b};
	endfunction

	function automatic logic [31:0] reg_addr(input logic [2:0] idx);
		return {8'h00, video_cfg_pkg::REGION_REGS, 15'h0, idx, 2'b00};
	endfunction

	function automatic logic [31:0] pal_addr(input int i);
		return {8'h00, video_cfg_pkg::REGION_PALETTE, 10'h0, i[7:0], 2'b00};
	endfunction

	// Colour for one x from the buffered line, as the pixel rules define it.
	function automatic logic [23:0] expected_rgb(input int x, input logic blank);
		logic [31:0] w;
		if (blank) begin
			return 24'h0;
		end
		if (cur_pal) begin
			if (x >= cur_pitch) begin
				return 24'h0;
			end
			w = model_word(buf_base + 32'(4 * (x / 4)));
			return pal_model[w[8 * (x % 4) +: 8]];
		end
		if (x >= cur_pitch / 4) begin
			return 24'h0;
		end
		w = model_word(buf_base + 32'(4 * x));
		return w[23:0];
	endfunction

	// Memory read port, answers on the falling edge.
	always @(negedge clock) begin
		if (vram_request && (!stall_en || $urandom_range(2) != 0)) begin
			vram_ready = 1'b1;
			vram_rdata = model_word(vram_address);
			fetch_log.push_back(vram_address);
		end else begin
			vram_ready = 1'b0;
			vram_rdata = 32'h0;
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic note_error(input string what);
		errors++;
		$display("Error at %0t: %s", $time, what);
	endtask

	task automatic report_counts();
		$display("Checks: %0d, errors: %0d", checks, errors);
	endtask

	// One CPU access with the ready latency and the ready level checked.
	task automatic cpu_access(input logic rw, input logic [31:0] addr,
		input logic [31:0] wdata, input int hold, input int exp_wait,
		output logic [31:0] rdata);
		int waited;
		@(negedge clock);
		cpu_request = 1'b1;
		cpu_req = '{rw: rw, address: addr, wdata: wdata};
		waited = 0;
		do begin
			@(negedge clock);
			waited++;
		end while (!cpu_ready && waited < 10);
		if (!cpu_ready) begin
			note_error("CPU access never got ready");
		end else begin
			check_value("o_cpu_ready latency", waited, exp_wait);
		end
		rdata = cpu_rdata;
		repeat (hold) begin
			@(negedge clock);
			check_value("o_cpu_ready", cpu_ready, 1'b1);
		end
		cpu_request = 1'b0;
		@(negedge clock);
		check_value("o_cpu_ready", cpu_ready, 1'b0);
		@(negedge clock);
	endtask

	task automatic reg_write(input logic [2:0] idx, input logic [31:0] value);
		logic [31:0] unused;
		cpu_access(1'b1, reg_addr(idx), value, 0, 1, unused);
	endtask

	task automatic reg_read(input logic [2:0] idx, input int hold, output logic [31:0] value);
		cpu_access(1'b0, reg_addr(idx), 32'h0, hold, 1, value);
	endtask

	task automatic pal_write(input int i, input logic [23:0] colour);
		logic [31:0] unused;
		cpu_access(1'b1, pal_addr(i), {8'h0, colour}, 0, 2, unused);
		pal_model[i] = colour;
	endtask

	task automatic set_config(input logic [31:0] offset, input int pitch, input logic pal);
		reg_write(video_cfg_pkg::REG_OFFSET, offset);
		reg_write(video_cfg_pkg::REG_PITCH, 32'(pitch));
		reg_write(video_cfg_pkg::REG_MODE, {31'h0, pal});
		cur_offset = offset;
		cur_pitch = pitch;
		cur_pal = pal;
	endtask

	// Frame restart, line count back to zero.
	task automatic vblank_pulse();
		@(negedge clock);
		raster.vblank = 1'b1;
		repeat (4) @(negedge clock);
		raster.vblank = 1'b0;
		repeat (4) @(negedge clock);
		line_num = 0;
	endtask

	task automatic wait_fetch_idle(input int limit);
		int waited;
		waited = 0;
		while (vram_request && waited < limit) begin
			@(negedge clock);
			waited++;
		end
		if (vram_request) begin
			note_error("line fetch did not finish");
		end
		// Let the last word land in the line buffer.
		repeat (3) @(negedge clock);
	endtask

	// Hblank edge, then the whole fetch checked against the address rule.
	task automatic fetch_line();
		int words;
		int waited;
		logic [31:0] base;
		words = cur_pitch / 4;
		base = cur_offset + 32'(line_num * cur_pitch);
		fetch_log.delete();
		@(negedge clock);
		raster.hblank = 1'b1;
		waited = 0;
		do begin
			@(negedge clock);
			waited++;
		end while (!vram_request && waited < 8);
		if (!vram_request) begin
			note_error("line fetch did not start after hblank");
		end else if (waited > 3) begin
			note_error("line fetch started late after hblank");
		end
		wait_fetch_idle(words * 16 + 16);
		check_value("o_vram_request count", fetch_log.size(), words);
		foreach (fetch_log[k]) begin
			check_value("o_vram_address", fetch_log[k], base + 32'(4 * k));
		end
		buf_base = base;
		line_num++;
		raster.hblank = 1'b0;
		repeat (3) @(negedge clock);
	endtask

	// Steps x and checks each colour three cycles later.
	task automatic scan_line(input int first_x, input int count, input logic hb,
		input logic vb);
		logic [23:0] exp_q [$];
		for (int i = 0; i < count + 3; i++) begin
			@(negedge clock);
			if (i >= 3) begin
				check_value("o_video_rgb", rgb, exp_q.pop_front());
			end
			if (i < count) begin
				raster.x = 11'(first_x + i);
				raster.hblank = hb;
				raster.vblank = vb;
				exp_q.push_back(expected_rgb(first_x + i, hb || vb));
			end
		end
		raster.hblank = 1'b0;
		raster.vblank = 1'b0;
		raster.x = 11'd0;
	endtask

	// ========================================================================
	// Directed tests.
	// ========================================================================

	task automatic test_registers();
		logic [31:0] value;
		reg_read(video_cfg_pkg::REG_OFFSET, 0, value);
		check_value("o_cpu_rdata offset", value, 32'h0);
		reg_read(video_cfg_pkg::REG_PITCH, 2, value);
		check_value("o_cpu_rdata pitch", value, 32'(MAX_PITCH));
		reg_read(video_cfg_pkg::REG_MODE, 0, value);
		check_value("o_cpu_rdata mode", value, 32'h1);
		set_config(32'h0001_2340, 12'h1A4, 1'b0);
		reg_read(video_cfg_pkg::REG_OFFSET, 1, value);
		check_value("o_cpu_rdata offset", value, 32'h0001_2340);
		reg_read(video_cfg_pkg::REG_PITCH, 0, value);
		check_value("o_cpu_rdata pitch", value, 32'h1A4);
		reg_read(video_cfg_pkg::REG_MODE, 0, value);
		check_value("o_cpu_rdata mode", value, 32'h0);
		// Unmapped address still completes.
		cpu_access(1'b0, 32'h0000_0040, 32'h0, 0, 1, value);
		check_value("o_cpu_rdata unmapped", value, 32'h0);
	endtask

	task automatic test_palette_mode();
		for (int i = 0; i < 256; i++) begin
			pal_write(i, palette_colour(i));
		end
		set_config(32'h0000_1000, 32, 1'b1);
		vblank_pulse();
		fetch_line();
		scan_line(0, cur_pitch + 4, 1'b0, 1'b0);
	endtask

	task automatic test_direct_mode();
		set_config(32'h0000_2000, 64, 1'b0);
		vblank_pulse();
		fetch_line();
		scan_line(0, cur_pitch / 4 + 4, 1'b0, 1'b0);
	endtask

	task automatic test_backpressure();
		set_config(32'h0000_1000, 32, 1'b1);
		vblank_pulse();
		stall_en = 1'b1;
		fetch_line();
		stall_en = 1'b0;
		scan_line(0, cur_pitch + 4, 1'b0, 1'b0);
	endtask

	task automatic test_frame_advance();
		vblank_pulse();
		fetch_line();
		fetch_line();
		scan_line(0, cur_pitch, 1'b0, 1'b0);
		vblank_pulse();
		fetch_line();
		scan_line(0, cur_pitch, 1'b0, 1'b0);
	endtask

	task automatic test_blanking();
		scan_line(cur_pitch, 8, 1'b0, 1'b0);
		scan_line(0, 8, 1'b0, 1'b1);
		line_num = 0;
		// Hblank edge here starts a fetch of its own.
		scan_line(0, 8, 1'b1, 1'b0);
		wait_fetch_idle(cur_pitch * 4 + 16);
		line_num++;
	endtask

	// ========================================================================
	// Run control.
	// ========================================================================

	always @(posedge clock) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			errors++;
			$display("Error: run stopped after %0d cycles without finishing", cycles);
			report_counts();
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	initial begin
		seed = $urandom(50);
		clock = 1'b0;
		rst_n = 1'b0;
		cpu_request = 1'b0;
		cpu_req = '{rw: 1'b0, address: 32'h0, wdata: 32'h0};
		raster = '{hblank: 1'b0, vblank: 1'b0, x: 11'd0, y: 11'd0};
		vram_ready = 1'b0;
		vram_rdata = 32'h0;
		errors = 0;
		checks = 0;
		cycles = 0;
		line_num = 0;
		cur_pitch = MAX_PITCH;
		cur_offset = 32'h0;
		cur_pal = 1'b1;
		buf_base = 32'h0;
		stall_en = 1'b0;

		repeat (4) @(posedge clock);
		@(negedge clock);
		check_value("o_cpu_ready", cpu_ready, 1'b0);
		check_value("o_vram_request", vram_request, 1'b0);
		check_value("o_video_rgb", rgb, 24'h0);
		rst_n = 1'b1;

		test_registers();
		test_palette_mode();
		test_direct_mode();
		test_backpressure();
		test_frame_advance();
		test_blanking();

		report_counts();
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- klara_video.f
verilog/video_cfg_pkg.sv
verilog/video_pix_pkg.sv
verilog/dual_port_ram.sv
verilog/video_regs.sv
verilog/line_fetch.sv
verilog/pixel_stage.sv
verilog/video_scanout.sv
bench/video_scanout_tb.sv

//--- verilog/dual_port_ram.sv
// One-read one-write synchronous RAM.
// Payload type set by parameter, registered read.

`timescale 1ns/1ps
`default_nettype none

module dual_port_ram #(
	parameter type T_DATA = logic [31:0],
	parameter int DEPTH = 160
)(
	input wire logic i_clock,

	input wire logic i_wr_en,
	input wire logic [$clog2(DEPTH)-1:0] i_wr_addr,
	input wire T_DATA i_wr_data,

	input wire logic [$clog2(DEPTH)-1:0] i_rd_addr,
	output T_DATA o_rd_data
);

	T_DATA mem [DEPTH];

	always_ff @(posedge i_clock) begin
		if (i_wr_en) begin
			mem[i_wr_addr] <= i_wr_data;
		end
	end

	// One cycle read latency.
	always_ff @(posedge i_clock) begin
		o_rd_data <= mem[i_rd_addr];
	end

	a_wr_in_range: assert property (
		@(posedge i_clock) i_wr_en |-> (int'(i_wr_addr) < DEPTH)
	);

endmodule

`default_nettype wire

//--- verilog/line_fetch.sv
// Per-line video memory reader.
// Blank synchronisers, row offset tracking and line buffer fill.

`timescale 1ns/1ps
`default_nettype none

module line_fetch #(
	parameter int MAX_PITCH = 640
)(
	input wire logic i_clock,
	input wire logic i_rst_n,

	input wire video_pix_pkg::raster_t i_raster,
	input wire video_cfg_pkg::video_cfg_t i_cfg,

	output logic o_vram_request,
	output logic [31:0] o_vram_address,
	input wire logic i_vram_ready,
	input wire logic [31:0] i_vram_rdata,

	output video_pix_pkg::line_wr_t o_line_wr
);

	logic [2:0] hb_sync;
	logic [2:0] vb_sync;
	logic hb_rise;
	logic vb_rise;
	logic start;
	logic take;
	logic [9:0] line_words;
	logic [9:0] word_idx;
	// Line number times pitch.
	logic [31:0] row_offset;
	logic wr_en;
	logic [9:0] wr_addr;
	logic [31:0] wr_data;

	assign hb_rise = hb_sync[1] && !hb_sync[2];
	assign vb_rise = vb_sync[1] && !vb_sync[2];

	// Never more words than the line buffer holds.
	assign line_words = (i_cfg.pitch > 12'(MAX_PITCH)) ? 10'(MAX_PITCH / 4) : i_cfg.pitch[11:2];

	assign start = hb_rise && !vb_sync[1] && !o_vram_request && (line_words != 10'd0);
	assign take = o_vram_request && i_vram_ready;

	// ========================================================================
	// Fetch control.
	// ========================================================================

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			hb_sync <= 3'b000;
			vb_sync <= 3'b000;
			row_offset <= 32'h0;
			word_idx <= 10'd0;
			o_vram_request <= 1'b0;
			o_vram_address <= 32'h0;
			wr_en <= 1'b0;
		end else begin
			hb_sync <= {hb_sync[1:0], i_raster.hblank};
			vb_sync <= {vb_sync[1:0], i_raster.vblank};
			wr_en <= take;

			// New frame restarts at the read offset.
			if (vb_rise) begin
				row_offset <= 32'h0;
			end

			if (start) begin
				o_vram_address <= i_cfg.read_offset + row_offset;
				row_offset <= row_offset + {20'h0, i_cfg.pitch};
				word_idx <= 10'd0;
				o_vram_request <= 1'b1;
			end else if (take) begin
				word_idx <= word_idx + 10'd1;
				if (word_idx + 10'd1 < line_words) begin
					o_vram_address <= o_vram_address + 32'd4;
				end else begin
					o_vram_request <= 1'b0;
				end
			end
		end
	end

	// Accepted word goes to its slot in the line.
	always_ff @(posedge i_clock) begin
		if (take) begin
			wr_addr <= word_idx;
			wr_data <= i_vram_rdata;
		end
	end

	assign o_line_wr = '{en: wr_en, addr: wr_addr, data: wr_data};

	a_req_held: assert property (
		@(posedge i_clock) disable iff (!i_rst_n)
		(o_vram_request && !i_vram_ready) |=> (o_vram_request && $stable(o_vram_address))
	);

endmodule

`default_nettype wire

//--- verilog/pixel_stage.sv
// Pixel output pipeline.
// Line buffer read, palette lookup, colour output register.
// Three cycles from raster position to colour.

`timescale 1ns/1ps
`default_nettype none

module pixel_stage #(
	parameter int MAX_PITCH = 640
)(
	input wire logic i_clock,
	input wire logic i_rst_n,

	input wire video_pix_pkg::raster_t i_raster,
	input wire video_cfg_pkg::video_cfg_t i_cfg,

	output logic [$clog2(MAX_PITCH/4)-1:0] o_line_rd_addr,
	input wire logic [31:0] i_line_rd_data,

	output logic [7:0] o_pal_rd_addr,
	input wire video_pix_pkg::rgb_t i_pal_rd_data,

	output video_pix_pkg::rgb_t o_video_rgb
);

	logic [10:0] word_addr;
	logic in_width;
	logic s1_valid;
	logic s1_pal;
	logic [1:0] s1_sel;
	logic s2_valid;
	logic s2_pal;
	video_pix_pkg::rgb_t s2_direct;

	// ========================================================================
	// Stage 1: word address and visibility.
	// ========================================================================

	always_comb begin
		if (i_cfg.use_palette) begin
			// Four palette indices per word.
			word_addr = {2'b00, i_raster.x[10:2]};
			in_width = {1'b0, i_raster.x} < i_cfg.pitch;
		end else begin
			word_addr = i_raster.x;
			in_width = {1'b0, i_raster.x} < {2'b00, i_cfg.pitch[11:2]};
		end
	end

	assign o_line_rd_addr = word_addr[$clog2(MAX_PITCH/4)-1:0];

	// Stage 2: byte of the buffered word as palette index.
	always_comb begin
		case (s1_sel)
			2'd0: o_pal_rd_addr = i_line_rd_data[7:0];
			2'd1: o_pal_rd_addr = i_line_rd_data[15:8];
			2'd2: o_pal_rd_addr = i_line_rd_data[23:16];
			default: o_pal_rd_addr = i_line_rd_data[31:24];
		endcase
	end

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			s1_valid <= 1'b0;
			s1_pal <= 1'b0;
			s1_sel <= 2'd0;
			s2_valid <= 1'b0;
			s2_pal <= 1'b0;
			o_video_rgb <= '0;
		end else begin
			s1_valid <= !i_raster.hblank && !i_raster.vblank && in_width &&
				(word_addr < 11'(MAX_PITCH / 4));
			s1_pal <= i_cfg.use_palette;
			s1_sel <= i_raster.x[1:0];
			s2_valid <= s1_valid;
			s2_pal <= s1_pal;

			// Stage 3: colour out, black when off screen.
			if (!s2_valid) begin
				o_video_rgb <= '0;
			end else if (s2_pal) begin
				o_video_rgb <= i_pal_rd_data;
			end else begin
				o_video_rgb <= s2_direct;
			end
		end
	end

	// Direct colour waits out the palette read.
	always_ff @(posedge i_clock) begin
		s2_direct <= i_line_rd_data[23:0];
	end

endmodule

`default_nettype wire

//--- verilog/video_cfg_pkg.sv
// Scanout configuration definitions.
// Register map region codes and register word indices.
// Configuration struct and CPU request struct.

`default_nettype none

package video_cfg_pkg;

	// Region codes in address bits 23:20.
	localparam logic [3:0] REGION_PALETTE = 4'hE;
	localparam logic [3:0] REGION_REGS = 4'hF;

	// Register word indices, address bits 4:2.
	localparam logic [2:0] REG_OFFSET = 3'd0;
	localparam logic [2:0] REG_PITCH = 3'd1;
	localparam logic [2:0] REG_MODE = 3'd2;

	typedef struct packed {
		logic [31:0] read_offset;
		logic [11:0] pitch;
		logic use_palette;
	} video_cfg_t;

	// Write when rw is set.
	typedef struct packed {
		logic rw;
		logic [31:0] address;
		logic [31:0] wdata;
	} cpu_req_t;

endpackage

`default_nettype wire

//--- verilog/video_pix_pkg.sv
// Pixel path definitions.
// Raster position, colour and RAM write port structs.

`default_nettype none

package video_pix_pkg;

	typedef struct packed {
		logic hblank;
		logic vblank;
		logic [10:0] x;
		logic [10:0] y;
	} raster_t;

	typedef logic [23:0] rgb_t;

	typedef struct packed {
		logic en;
		logic [7:0] addr;
		rgb_t data;
	} palette_wr_t;

	typedef struct packed {
		logic en;
		logic [9:0] addr;
		logic [31:0] data;
	} line_wr_t;

endpackage

`default_nettype wire

//--- verilog/video_regs.sv
// CPU register decoder for the scanout.
// Holds offset, pitch and mode registers, issues palette writes.

`timescale 1ns/1ps
`default_nettype none

module video_regs #(
	parameter int MAX_PITCH = 640
)(
	input wire logic i_clock,
	input wire logic i_rst_n,

	input wire logic i_cpu_request,
	input wire video_cfg_pkg::cpu_req_t i_cpu_req,
	output logic o_cpu_ready,
	output logic [31:0] o_cpu_rdata,

	output video_cfg_pkg::video_cfg_t o_cfg,
	output video_pix_pkg::palette_wr_t o_pal_wr
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_PAL_WRITE,
		S_READY,
		S_WAIT_END
	} state_t;

	state_t state;
	logic [3:0] region;
	logic [2:0] reg_sel;
	logic accept;
	logic pal_en;
	logic [7:0] pal_addr;
	video_pix_pkg::rgb_t pal_data;

	assign region = i_cpu_req.address[23:20];
	assign reg_sel = i_cpu_req.address[4:2];
	assign accept = (state == S_IDLE) && i_cpu_request;

	// ========================================================================
	// Handshake FSM and configuration registers.
	// ========================================================================

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= S_IDLE;
			o_cpu_ready <= 1'b0;
			pal_en <= 1'b0;
			o_cfg <= '{read_offset: 32'h0, pitch: 12'(MAX_PITCH), use_palette: 1'b1};
		end else begin
			pal_en <= 1'b0;
			unique case (state)
				S_IDLE: begin
					o_cpu_ready <= 1'b0;
					if (i_cpu_request) begin
						if (region == video_cfg_pkg::REGION_PALETTE) begin
							// Strobe goes out first, ready follows.
							pal_en <= i_cpu_req.rw;
							state <= S_PAL_WRITE;
						end else begin
							if (region == video_cfg_pkg::REGION_REGS && i_cpu_req.rw) begin
								case (reg_sel)
									video_cfg_pkg::REG_OFFSET: o_cfg.read_offset <= i_cpu_req.wdata;
									video_cfg_pkg::REG_PITCH: o_cfg.pitch <= i_cpu_req.wdata[11:0];
									video_cfg_pkg::REG_MODE: o_cfg.use_palette <= i_cpu_req.wdata[0];
									default: ;
								endcase
							end
							o_cpu_ready <= 1'b1;
							state <= S_READY;
						end
					end
				end
				S_PAL_WRITE: begin
					o_cpu_ready <= 1'b1;
					state <= S_READY;
				end
				S_READY: begin
					o_cpu_ready <= i_cpu_request;
					state <= S_WAIT_END;
				end
				S_WAIT_END: begin
					// Hold ready until the CPU lets go.
					o_cpu_ready <= i_cpu_request;
					if (!i_cpu_request) begin
						state <= S_IDLE;
					end
				end
			endcase
		end
	end

	// Read data and palette payload.
	always_ff @(posedge i_clock) begin
		if (accept) begin
			pal_addr <= i_cpu_req.address[9:2];
			pal_data <= i_cpu_req.wdata[23:0];
			o_cpu_rdata <= 32'h0;
			if (region == video_cfg_pkg::REGION_REGS && !i_cpu_req.rw) begin
				case (reg_sel)
					video_cfg_pkg::REG_OFFSET: o_cpu_rdata <= o_cfg.read_offset;
					video_cfg_pkg::REG_PITCH: o_cpu_rdata <= {20'h0, o_cfg.pitch};
					video_cfg_pkg::REG_MODE: o_cpu_rdata <= {31'h0, o_cfg.use_palette};
					default: o_cpu_rdata <= 32'h0;
				endcase
			end
		end
	end

	assign o_pal_wr = '{en: pal_en, addr: pal_addr, data: pal_data};

	a_ready_follows_req: assert property (
		@(posedge i_clock) disable iff (!i_rst_n)
		(o_cpu_ready && !i_cpu_request) |-> $past(i_cpu_request)
	);

endmodule

`default_nettype wire

//--- verilog/video_scanout.sv
// Video scanout top level.
// Register stage, line fetch, pixel stage, line buffer and palette RAMs.

`timescale 1ns/1ps
`default_nettype none

module video_scanout #(
	parameter int MAX_PITCH = 640
)(
	input wire logic i_clock,
	input wire logic i_rst_n,

	// CPU.
	input wire logic i_cpu_request,
	input wire video_cfg_pkg::cpu_req_t i_cpu_req,
	output logic o_cpu_ready,
	output logic [31:0] o_cpu_rdata,

	// Display.
	input wire video_pix_pkg::raster_t i_raster,
	output video_pix_pkg::rgb_t o_video_rgb,

	// Video memory read port.
	output logic o_vram_request,
	output logic [31:0] o_vram_address,
	input wire logic i_vram_ready,
	input wire logic [31:0] i_vram_rdata
);

	localparam int LINE_DEPTH = MAX_PITCH / 4;
	localparam int LINE_AW = $clog2(LINE_DEPTH);

	video_cfg_pkg::video_cfg_t cfg;
	video_pix_pkg::palette_wr_t pal_wr;
	video_pix_pkg::line_wr_t line_wr;
	logic [LINE_AW-1:0] line_rd_addr;
	logic [31:0] line_rd_data;
	logic [7:0] pal_rd_addr;
	video_pix_pkg::rgb_t pal_rd_data;

	video_regs #(
		.MAX_PITCH(MAX_PITCH)
	) u_regs (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_cpu_request(i_cpu_request),
		.i_cpu_req(i_cpu_req),
		.o_cpu_ready(o_cpu_ready),
		.o_cpu_rdata(o_cpu_rdata),
		.o_cfg(cfg),
		.o_pal_wr(pal_wr)
	);

	line_fetch #(
		.MAX_PITCH(MAX_PITCH)
	) u_fetch (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_raster(i_raster),
		.i_cfg(cfg),
		.o_vram_request(o_vram_request),
		.o_vram_address(o_vram_address),
		.i_vram_ready(i_vram_ready),
		.i_vram_rdata(i_vram_rdata),
		.o_line_wr(line_wr)
	);

	dual_port_ram #(
		.T_DATA(logic [31:0]),
		.DEPTH(LINE_DEPTH)
	) line_ram (
		.i_clock(i_clock),
		.i_wr_en(line_wr.en),
		.i_wr_addr(line_wr.addr[LINE_AW-1:0]),
		.i_wr_data(line_wr.data),
		.i_rd_addr(line_rd_addr),
		.o_rd_data(line_rd_data)
	);

	dual_port_ram #(
		.T_DATA(video_pix_pkg::rgb_t),
		.DEPTH(256)
	) palette_ram (
		.i_clock(i_clock),
		.i_wr_en(pal_wr.en),
		.i_wr_addr(pal_wr.addr),
		.i_wr_data(pal_wr.data),
		.i_rd_addr(pal_rd_addr),
		.o_rd_data(pal_rd_data)
	);

	pixel_stage #(
		.MAX_PITCH(MAX_PITCH)
	) u_pixel (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_raster(i_raster),
		.i_cfg(cfg),
		.o_line_rd_addr(line_rd_addr),
		.i_line_rd_data(line_rd_data),
		.o_pal_rd_addr(pal_rd_addr),
		.i_pal_rd_data(pal_rd_data),
		.o_video_rgb(o_video_rgb)
	);

endmodule

`default_nettype wire
